//--- hdl/core_pixel.sv
`timescale 1ns/1ns
`default_nettype none

module core_pixel (
    input  wire                    I_CP_HCLK,
    input  wire                    I_CP_HRESET_N,
    input  wire logic              dma_ready, // one beat per high clock
    input  wire logic              stop,
    input  wire logic              abort,
    input  wire pixel_pkg::rot_t   degrees,
    output pixel_pkg::addr_group_t in_addr,
    output pixel_pkg::addr_group_t out_addr
);

    import seq_pkg::*;

    seq_status_t status;

    transfer_sequencer u_seq (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .dma_ready     (dma_ready),
        .stop          (stop),
        .abort         (abort),
        .status        (status)
    );

    // incoming pixel side
    read_addr_gen u_rd (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .status        (status),
        .in_addr       (in_addr)
    );

    // outgoing side, combinational from bases
    write_addr_gen u_wr (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .status        (status),
        .degrees       (degrees),
        .out_addr      (out_addr)
    );

endmodule

`default_nettype wire

//--- hdl/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

    localparam int ADDR_W = 8;
    localparam int LANES  = 4;

    typedef logic [ADDR_W-1:0] addr_t;

    // lane0 in the low byte
    typedef struct packed {
        addr_t lane3;
        addr_t lane2;
        addr_t lane1;
        addr_t lane0;
    } addr_group_t;

    typedef enum logic {
        rot_0   = 1'b0,
        rot_180 = 1'b1
    } rot_t;

    localparam addr_t AHB_STEP = 8'd4;

    localparam addr_group_t IN_DEFAULT = '{lane3: 8'd3, lane2: 8'd2, lane1: 8'd1, lane0: 8'd0};

    localparam addr_t START_0   = 8'h00;
    localparam addr_t START_180 = 8'hbc;

    // 180 deg lane offsets, negative values wrap mod 256
    localparam addr_group_t OFF180_A = '{lane3: 8'hfe, lane2: 8'd3, lane1: 8'd2, lane0: 8'd1};
    localparam addr_group_t OFF180_B = '{lane3: 8'd0, lane2: 8'hff, lane1: 8'd4, lane0: 8'd3};
    localparam addr_group_t OFF180_C = '{lane3: 8'd2, lane2: 8'd1, lane1: 8'd0, lane0: 8'd5};

    // beats of each group of eight where addresses hold
    localparam logic [2:0] HOLD_BEAT_A = 3'd5;
    localparam logic [2:0] HOLD_BEAT_B = 3'd6;

endpackage

`default_nettype wire

//--- hdl/read_addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

module read_addr_gen (
    input  wire                       I_CP_HCLK,
    input  wire                       I_CP_HRESET_N,
    input  wire seq_pkg::seq_status_t status,
    output pixel_pkg::addr_group_t    in_addr
);

    import seq_pkg::*;
    import pixel_pkg::*;

    logic hold;

    assign hold = (status.beat == HOLD_BEAT_A) || (status.beat == HOLD_BEAT_B);

    always_ff @(posedge I_CP_HCLK)
        if (!I_CP_HRESET_N)
            in_addr <= IN_DEFAULT;
        else if (status.flush)
            in_addr <= '0;
        else if (status.next_state != read)
            in_addr <= IN_DEFAULT;
        else if (status.last)
            in_addr <= IN_DEFAULT; // back to buffer start when the transfer ends
        else if (!hold)
        begin
            in_addr.lane0 <= in_addr.lane0 + AHB_STEP;
            in_addr.lane1 <= in_addr.lane1 + AHB_STEP;
            in_addr.lane2 <= in_addr.lane2 + AHB_STEP;
            in_addr.lane3 <= in_addr.lane3 + AHB_STEP;
        end

    // after a flush the walk keeps all lanes equal until the next reload
    a_lane_shape: assert property (
        @(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N)
        ((in_addr.lane1 == addr_t'(in_addr.lane0 + 8'd1)) &&
         (in_addr.lane2 == addr_t'(in_addr.lane0 + 8'd2)) &&
         (in_addr.lane3 == addr_t'(in_addr.lane0 + 8'd3))) ||
        ((in_addr.lane1 == in_addr.lane0) &&
         (in_addr.lane2 == in_addr.lane0) &&
         (in_addr.lane3 == in_addr.lane0))
    );

endmodule

`default_nettype wire

//--- hdl/seq_pkg.sv
`default_nettype none

package seq_pkg;

    localparam int TRANS_W = 6;
    localparam int BEAT_W  = 3;

    localparam logic [TRANS_W-1:0] LAST_TRANS = 6'd63; // 64 beats per transfer

    typedef enum logic [1:0] {
        idle  = 2'd0,
        read  = 2'd1,
        write = 2'd2
    } seq_state_t;

    // sequencer view shared by both address generators
    typedef struct packed {
        seq_state_t        state;
        seq_state_t        next_state;
        logic [BEAT_W-1:0] beat;       // low bits of the transfer count
        logic              last;
        logic              flush;      // stop seen this clock
    } seq_status_t;

endpackage

`default_nettype wire

//--- hdl/transfer_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module transfer_sequencer (
    input  wire                  I_CP_HCLK,
    input  wire                  I_CP_HRESET_N,
    input  wire logic            dma_ready,
    input  wire logic            stop,
    input  wire logic            abort,
    output seq_pkg::seq_status_t status
);

    import seq_pkg::*;

    seq_state_t         state;
    seq_state_t         next_state;
    logic [TRANS_W-1:0] count;
    logic               last;

    assign last = (count == LAST_TRANS);

    always_ff @(posedge I_CP_HCLK)
        if (!I_CP_HRESET_N)
            state <= idle;
        else
            state <= next_state;

    // abort wins over the end of a transfer
    always_comb
    begin
        next_state = state;
        case (state)
            idle:
                if (dma_ready)
                    next_state = read;
            read:
                if (abort)
                    next_state = idle;
                else if (last)
                    next_state = write;
            write:
                if (abort)
                    next_state = idle;
                else if (last)
                    next_state = read;
            default:
                next_state = idle;
        endcase
    end

    // beat counter, wraps at 64
    always_ff @(posedge I_CP_HCLK)
        if (!I_CP_HRESET_N)
            count <= '0;
        else if (stop)
            count <= '0; // stop has priority
        else if (dma_ready)
            count <= count + 1'b1;

    assign status = '{
        state:      state,
        next_state: next_state,
        beat:       count[BEAT_W-1:0],
        last:       last,
        flush:      stop
    };

    a_state_legal: assert property (
        @(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N)
        state inside {idle, read, write}
    );

    a_abort_idle: assert property (
        @(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N)
        (abort && (state inside {read, write})) |=> (state == idle)
    );

endmodule

`default_nettype wire

//--- hdl/write_addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

module write_addr_gen (
    input  wire                       I_CP_HCLK,
    input  wire                       I_CP_HRESET_N,
    input  wire seq_pkg::seq_status_t status,
    input  wire pixel_pkg::rot_t      degrees,
    output pixel_pkg::addr_group_t    out_addr
);

    import seq_pkg::*;
    import pixel_pkg::*;

    addr_t       base0;
    addr_t       base180;
    logic        hold;
    addr_group_t off180;
    addr_group_t lanes_0;
    addr_group_t lanes_180;

    assign hold = (status.beat == HOLD_BEAT_A) || (status.beat == HOLD_BEAT_B);

    // 0 deg scans forward, 180 deg backward, one lane group per beat
    always_ff @(posedge I_CP_HCLK)
        if (!I_CP_HRESET_N)
        begin
            base0   <= START_0;
            base180 <= START_180;
        end
        else
            case (status.next_state)
                idle:
                begin
                    base0   <= START_0;
                    base180 <= START_180;
                end
                write:
                    if (status.last)
                    begin
                        base0   <= START_0;
                        base180 <= START_180;
                    end
                    else if (!hold)
                    begin
                        base0   <= base0 + addr_t'(LANES);
                        base180 <= base180 - addr_t'(LANES);
                    end
                default:
                begin
                    base0   <= base0; // read phase, bases wait
                    base180 <= base180;
                end
            endcase

    // 180 deg offset pattern repeats over beats 0-2 and 3-4
    always_comb
    begin
        off180 = OFF180_C;
        if (status.state == write)
            case (status.beat)
                3'd0, 3'd3: off180 = OFF180_A;
                3'd1, 3'd4: off180 = OFF180_B;
                default:    off180 = OFF180_C;
            endcase
    end

    always_comb
    begin
        lanes_0.lane0 = base0;
        lanes_0.lane1 = base0 + 8'd1;
        lanes_0.lane2 = base0 + 8'd2;
        lanes_0.lane3 = base0 + 8'd3;
    end

    always_comb
    begin
        lanes_180.lane0 = base180 + off180.lane0;
        lanes_180.lane1 = base180 + off180.lane1;
        lanes_180.lane2 = base180 + off180.lane2;
        lanes_180.lane3 = base180 + off180.lane3;
    end

    assign out_addr = (degrees == rot_180) ? lanes_180 : lanes_0;

    a_rot0_consecutive: assert property (
        @(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N)
        (degrees == rot_0) |->
            ((out_addr.lane1 == addr_t'(out_addr.lane0 + 8'd1)) &&
             (out_addr.lane2 == addr_t'(out_addr.lane0 + 8'd2)) &&
             (out_addr.lane3 == addr_t'(out_addr.lane0 + 8'd3)))
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the core_pixel testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
    --top-module core_pixel_tb -o core_pixel_sim

sim_out=$(./obj_dir/core_pixel_sim)
echo "$sim_out"

# a missing pass line makes grep fail the script
echo "$sim_out" | grep -q "^STATUS: PASS$"

//--- sources.f
hdl/seq_pkg.sv
hdl/pixel_pkg.sv
hdl/transfer_sequencer.sv
hdl/read_addr_gen.sv
hdl/write_addr_gen.sv
hdl/core_pixel.sv
verification/core_pixel_tb.sv

//--- verification/core_pixel_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_pixel_tb;

    import seq_pkg::*;
    import pixel_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_WAIT     = 200; // beats allowed for one state change
    localparam int BEATS_TOTAL  = RESET_CYCLES + 40 + 10 * MAX_WAIT;
    localparam int WATCHDOG_NS  = BEATS_TOTAL * 2 * CLK_HALF * 2;

    localparam addr_group_t DEFAULTS = {8'd3, 8'd2, 8'd1, 8'd0};

    // 180 deg offsets per lane, rows are sets A, B and C
    localparam addr_t OFFSETS [3][4] = '{
        '{8'd1, 8'd2, 8'd3, 8'hfe},
        '{8'd3, 8'd4, 8'hff, 8'd0},
        '{8'd5, 8'd0, 8'd1, 8'd2}
    };

    logic        I_CP_HCLK;
    logic        I_CP_HRESET_N;
    logic        dma_ready;
    logic        stop;
    logic        abort;
    rot_t        degrees;
    addr_group_t in_addr;
    addr_group_t out_addr;

    seq_state_t  m_state;
    seq_state_t  m_next;
    logic [5:0]  m_count;
    logic [2:0]  m_beat;
    logic        m_last;
    logic        m_hold;
    addr_group_t m_in;
    addr_t       m_base0;
    addr_t       m_base180;
    int          off_sel;
    addr_group_t exp_out;

    int err_count;
    int err_mark;
    int tests_passed;
    int tests_failed;

    core_pixel dut (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .dma_ready     (dma_ready),
        .stop          (stop),
        .abort         (abort),
        .degrees       (degrees),
        .in_addr       (in_addr),
        .out_addr      (out_addr)
    );

    always #CLK_HALF I_CP_HCLK = ~I_CP_HCLK;

    assign m_beat = m_count[2:0];
    assign m_last = (m_count == 6'd63);
    assign m_hold = (m_beat == 3'd5) || (m_beat == 3'd6);

    always_comb
    begin
        case (m_state)
            idle:    m_next = dma_ready ? read : idle;
            read:    m_next = abort ? idle : (m_last ? write : read);
            write:   m_next = abort ? idle : (m_last ? read : write);
            default: m_next = idle;
        endcase
    end

    // expected outgoing lanes, set C outside write
    always_comb
    begin
        exp_out = '0;
        off_sel = 2;
        if (m_state == write && (m_beat == 3'd0 || m_beat == 3'd3))
            off_sel = 0;
        else if (m_state == write && (m_beat == 3'd1 || m_beat == 3'd4))
            off_sel = 1;
        for (int k = 0; k < 4; k++)
            if (degrees == rot_0)
                exp_out[8*k +: 8] = m_base0 + 8'(k);
            else
                exp_out[8*k +: 8] = m_base180 + OFFSETS[off_sel][k];
    end

    always @(posedge I_CP_HCLK)
        if (!I_CP_HRESET_N)
        begin
            m_state   <= idle;
            m_count   <= '0;
            m_in      <= DEFAULTS;
            m_base0   <= 8'h00;
            m_base180 <= 8'hbc;
        end
        else
        begin
            m_state <= m_next;
            if (stop)
                m_count <= '0;
            else if (dma_ready)
                m_count <= m_count + 6'd1;
            if (stop)
                m_in <= '0;
            else if (m_next != read || m_last)
                m_in <= DEFAULTS;
            else if (!m_hold)
            begin
                m_in.lane0 <= m_in.lane0 + 8'd4;
                m_in.lane1 <= m_in.lane1 + 8'd4;
                m_in.lane2 <= m_in.lane2 + 8'd4;
                m_in.lane3 <= m_in.lane3 + 8'd4;
            end
            if (m_next == idle || (m_next == write && m_last))
            begin
                m_base0   <= 8'h00;
                m_base180 <= 8'hbc;
            end
            else if (m_next == write && !m_hold)
            begin
                m_base0   <= m_base0 + 8'd4; // forward scan
                m_base180 <= m_base180 - 8'd4;
            end
        end

    a_reset_values: assert property (
        @(posedge I_CP_HCLK)
        $rose(I_CP_HRESET_N) |-> (in_addr == DEFAULTS) && (out_addr == exp_out)
    )
    else
    begin
        err_count++;
        $display("Fail %0t: after reset in_addr %h out_addr %h", $time,
                 $sampled(in_addr), $sampled(out_addr));
    end

    a_in_match: assert property (
        @(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N) in_addr == m_in
    )
    else
    begin
        err_count++;
        $display("Fail %0t: in_addr %h, expected %h", $time, $sampled(in_addr), $sampled(m_in));
    end

    a_out_match: assert property (
        @(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N) out_addr == exp_out
    )
    else
    begin
        err_count++;
        $display("Fail %0t: out_addr %h, expected %h", $time,
                 $sampled(out_addr), $sampled(exp_out));
    end

    // reads stay parked while the write phase runs
    a_write_defaults: assert property (
        @(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N)
        (m_state == write && !$past(stop)) |-> (in_addr == DEFAULTS)
    )
    else
    begin
        err_count++;
        $display("Fail %0t: in_addr %h left defaults during write", $time, $sampled(in_addr));
    end

    a_stop_zero: assert property (
        @(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N) stop |=> (in_addr == '0)
    )
    else
    begin
        err_count++;
        $display("Fail %0t: in_addr %h not cleared by stop", $time, $sampled(in_addr));
    end

    function automatic logic random_ready();
        return ($urandom % 100) < 80;
    endfunction

    function automatic rot_t random_rot();
        return ($urandom % 2 == 32'd0) ? rot_0 : rot_180;
    endfunction

    task automatic drive_beat(input logic ready, input rot_t deg, input logic stp,
                              input logic abt);
        @(posedge I_CP_HCLK);
        dma_ready <= ready;
        degrees   <= deg;
        stop      <= stp;
        abort     <= abt;
        @(negedge I_CP_HCLK);
    endtask

    task automatic run_random_beats(input int n);
        repeat (n) drive_beat(random_ready(), random_rot(), 1'b0, 1'b0);
    endtask

    task automatic run_until_state(input seq_state_t target, input logic rand_deg,
                                   input rot_t deg);
        int beats;
        beats = 0;
        while (m_state != target && beats < MAX_WAIT)
        begin
            drive_beat(random_ready(), rand_deg ? random_rot() : deg, 1'b0, 1'b0);
            beats++;
        end
        if (m_state != target)
        begin
            err_count++;
            $display("sequencer did not reach %s within %0d beats", target.name(), MAX_WAIT);
        end
    endtask

    task automatic close_test(input string name);
        if (err_count == err_mark)
        begin
            tests_passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    initial
    begin
        #WATCHDOG_NS;
        $display("watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(32'hb226));
        I_CP_HCLK     = 1'b0;
        I_CP_HRESET_N = 1'b0;
        dma_ready     = 1'b0;
        stop          = 1'b0;
        abort         = 1'b0;
        degrees       = rot_0;
        err_count     = 0;
        err_mark      = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        repeat (RESET_CYCLES) @(posedge I_CP_HCLK);
        I_CP_HRESET_N <= 1'b1;
        @(negedge I_CP_HCLK);

        drive_beat(1'b0, rot_0, 1'b0, 1'b0); // idle, no ready
        drive_beat(1'b0, rot_0, 1'b0, 1'b0);
        drive_beat(1'b0, rot_180, 1'b0, 1'b0);
        drive_beat(1'b0, rot_180, 1'b0, 1'b0);
        close_test("reset values");

        run_until_state(write, 1'b1, rot_0);
        close_test("read walk");

        run_until_state(read, 1'b0, rot_0);
        close_test("write at 0 deg");

        run_until_state(write, 1'b1, rot_0);
        run_until_state(read, 1'b0, rot_180);
        close_test("write at 180 deg");

        run_random_beats(5);
        drive_beat(random_ready(), random_rot(), 1'b1, 1'b0);
        run_random_beats(5);
        drive_beat(random_ready(), random_rot(), 1'b0, 1'b1); // abort during read
        run_random_beats(2);
        run_until_state(write, 1'b1, rot_0);
        drive_beat(random_ready(), random_rot(), 1'b0, 1'b1);
        run_random_beats(3);
        close_test("stop and abort");

        run_until_state(read, 1'b1, rot_0);
        run_until_state(write, 1'b1, rot_0);
        run_until_state(read, 1'b1, rot_0);
        run_until_state(write, 1'b1, rot_0);
        run_until_state(read, 1'b1, rot_0);
        close_test("two transfers");

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
